// File: src/rv64_pkg.sv
/*
 * RV64 architectural constants shared by the execute cluster.
 * Physical register 0 always reads as zero and is never written.
 */
package rv64_pkg;

	// Data path width.
	localparam int unsigned xlen = 64;

	// Width of a shift amount in 64-bit mode. W forms use one bit less.
	localparam int unsigned shamt_w = 6;

	// Physical register file size and index width.
	localparam int unsigned preg_num = 64;
	localparam int unsigned preg_w = 6;

	// Size of one instruction in bytes, used for the link value.
	localparam int unsigned inst_bytes = 4;

endpackage

// File: src/exe_pkg.sv
/*
 * Micro-op function codes, issue structs and result structs of the execute cluster.
 * Slot A always carries an ALU op and slot B a branch or jump.
 */
package exe_pkg;

	// ALU function codes. Values above alu_sra are illegal.
	typedef enum logic [3:0] {
		alu_imm,
		alu_add,
		alu_sub,
		alu_slt,
		alu_xor,
		alu_or,
		alu_and,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_fun_e;

	typedef enum logic [2:0] {
		bru_beq,
		bru_bne,
		bru_blt,
		bru_bge,
		bru_bltu,
		bru_bgeu,
		bru_jal,
		bru_jalr
	} bru_fun_e;

	typedef struct packed {
		logic valid;
		alu_fun_e fun;
		logic is32w;
		logic is_usi;
		logic is_imm;
		logic is_shamt;
		logic [rv64_pkg::preg_w-1:0] rs1;
		logic [rv64_pkg::preg_w-1:0] rs2;
		logic [rv64_pkg::preg_w-1:0] rd;
		logic [rv64_pkg::xlen-1:0] pc;
		logic [rv64_pkg::xlen-1:0] imm;
	} alu_issue_t;

	typedef struct packed {
		logic valid;
		bru_fun_e fun;
		logic [rv64_pkg::preg_w-1:0] rs1;
		logic [rv64_pkg::preg_w-1:0] rs2;
		logic [rv64_pkg::preg_w-1:0] rd;
		logic [rv64_pkg::xlen-1:0] pc;
		logic [rv64_pkg::xlen-1:0] imm;
	} bru_issue_t;

	// Register writeback of one unit.
	typedef struct packed {
		logic valid;
		logic [rv64_pkg::preg_w-1:0] rd;
		logic [rv64_pkg::xlen-1:0] res;
	} wb_t;

	typedef struct packed {
		logic valid;
		logic [rv64_pkg::xlen-1:0] pc;
	} redirect_t;

endpackage

// File: src/phys_regfile.sv
/*
 * Physical register file, four combinational reads and two writes, cleared at reset.
 * No write-to-read bypass: a read in the write cycle returns the old value.
 */
`timescale 1ns/1ps

module phys_regfile (
	input logic CLK,
	input logic rst_n,
	input logic [rv64_pkg::preg_w-1:0] ra_idx [4],
	output logic [rv64_pkg::xlen-1:0] ra_data [4],
	input logic we_a,
	input logic we_b,
	input logic [rv64_pkg::preg_w-1:0] wa_idx,
	input logic [rv64_pkg::preg_w-1:0] wb_idx,
	input logic [rv64_pkg::xlen-1:0] wa_data,
	input logic [rv64_pkg::xlen-1:0] wb_data
);

	logic [rv64_pkg::xlen-1:0] regs [rv64_pkg::preg_num];

	// Entry 0 is only ever cleared, so the read mux forces it to zero as well.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rv64_pkg::preg_num; i++) regs[i] <= '0;
		end else begin
			for (int i = 1; i < rv64_pkg::preg_num; i++) begin
				// Port B holds the younger op and wins a collision.
				if (we_b && wb_idx == rv64_pkg::preg_w'(i))
					regs[i] <= wb_data;
				else if (we_a && wa_idx == rv64_pkg::preg_w'(i))
					regs[i] <= wa_data;
			end
		end
	end

	always_comb begin
		for (int p = 0; p < 4; p++)
			ra_data[p] = (ra_idx[p] == '0) ? '0 : regs[ra_idx[p]];
	end

endmodule

// File: src/alu_exe.sv
/*
 * One-cycle integer ALU. W forms sign-extend the result from bit 31.
 * The imm function adds the immediate to the pc, as for auipc.
 */
`timescale 1ns/1ps

module alu_exe (
	input logic CLK,
	input logic rst_n,
	input logic flush,
	input exe_pkg::alu_issue_t iss,
	input logic [rv64_pkg::xlen-1:0] src1,
	input logic [rv64_pkg::xlen-1:0] src2,
	output exe_pkg::wb_t wb
);

	localparam int unsigned xw = rv64_pkg::xlen;
	localparam int unsigned hw = rv64_pkg::xlen / 2;

	logic fun_imm, fun_add, fun_sub, fun_slt, fun_xor;
	logic fun_or, fun_and, fun_sll, fun_srl, fun_sra;

	logic [xw-1:0] adder_op1, adder_op2, adder_sum;
	logic [xw-1:0] log_op2;
	logic [xw-1:0] slt_res;
	logic [rv64_pkg::shamt_w-1:0] shamt_src, shamt;
	logic [xw-1:0] sl_res;
	logic signed [xw:0] sr_op, sr_shifted;
	logic [xw-1:0] res_raw, res_d;

	logic valid_q;
	logic [rv64_pkg::preg_w-1:0] rd_q;
	logic [xw-1:0] res_q;

	assign fun_imm = (iss.fun == exe_pkg::alu_imm);
	assign fun_add = (iss.fun == exe_pkg::alu_add);
	assign fun_sub = (iss.fun == exe_pkg::alu_sub);
	assign fun_slt = (iss.fun == exe_pkg::alu_slt);
	assign fun_xor = (iss.fun == exe_pkg::alu_xor);
	assign fun_or = (iss.fun == exe_pkg::alu_or);
	assign fun_and = (iss.fun == exe_pkg::alu_and);
	assign fun_sll = (iss.fun == exe_pkg::alu_sll);
	assign fun_srl = (iss.fun == exe_pkg::alu_srl);
	assign fun_sra = (iss.fun == exe_pkg::alu_sra);

	// Shared adder for imm, add and sub.
	assign adder_op1 = fun_imm ? iss.pc : src1;
	assign adder_op2 = (iss.is_imm || fun_imm) ? iss.imm : (fun_sub ? (~src2 + 1'b1) : src2);
	assign adder_sum = adder_op1 + adder_op2;

	// Logic ops and compares share the second operand.
	assign log_op2 = iss.is_imm ? iss.imm : src2;
	assign slt_res = iss.is_usi ? xw'($unsigned(src1) < $unsigned(log_op2))
		: xw'($signed(src1) < $signed(log_op2));

	// In W mode the top bit of the amount is ignored.
	assign shamt_src = iss.is_shamt ? iss.imm[rv64_pkg::shamt_w-1:0]
		: src2[rv64_pkg::shamt_w-1:0];
	assign shamt = iss.is32w ? {1'b0, shamt_src[rv64_pkg::shamt_w-2:0]} : shamt_src;

	assign sl_res = src1 << shamt;

	// The extra top bit carries the fill value, zero for srl.
	assign sr_op = iss.is32w ? {{(hw+1){src1[hw-1] & fun_sra}}, src1[hw-1:0]}
		: {src1[xw-1] & fun_sra, src1};
	assign sr_shifted = sr_op >>> shamt;

	assign res_raw = ({xw{fun_imm | fun_add | fun_sub}} & adder_sum)
		| ({xw{fun_slt}} & slt_res)
		| ({xw{fun_xor}} & (src1 ^ log_op2))
		| ({xw{fun_or}} & (src1 | log_op2))
		| ({xw{fun_and}} & (src1 & log_op2))
		| ({xw{fun_sll}} & sl_res)
		| ({xw{fun_srl | fun_sra}} & sr_shifted[xw-1:0]);

	assign res_d = iss.is32w ? {{hw{res_raw[hw-1]}}, res_raw[hw-1:0]} : res_raw;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= iss.valid & ~flush;
	end

	always_ff @(posedge CLK) begin
		rd_q <= iss.rd;
		res_q <= res_d;
	end

	assign wb = '{valid: valid_q, rd: rd_q, res: res_q};

	// An issued op must decode to exactly one function.
	fun_legal: assert property (@(posedge CLK) disable iff (!rst_n)
		iss.valid |-> $onehot({fun_imm, fun_add, fun_sub, fun_slt, fun_xor,
			fun_or, fun_and, fun_sll, fun_srl, fun_sra}));

endmodule

// File: src/bru_exe.sv
/*
 * One-cycle branch unit. Conditional branches never write a register.
 * jal and jalr are always taken and write pc + 4 to rd.
 */
`timescale 1ns/1ps

module bru_exe (
	input logic CLK,
	input logic rst_n,
	input logic flush,
	input exe_pkg::bru_issue_t iss,
	input logic [rv64_pkg::xlen-1:0] src1,
	input logic [rv64_pkg::xlen-1:0] src2,
	output exe_pkg::wb_t wb,
	output exe_pkg::redirect_t redir
);

	logic is_eq, is_lt, is_ltu;
	logic taken, is_jump;
	logic [rv64_pkg::xlen-1:0] target, link;

	logic wb_valid_q, redir_valid_q;
	logic [rv64_pkg::preg_w-1:0] rd_q;
	logic [rv64_pkg::xlen-1:0] link_q, target_q;

	assign is_eq = (src1 == src2);
	assign is_lt = ($signed(src1) < $signed(src2));
	assign is_ltu = (src1 < src2);

	assign is_jump = (iss.fun == exe_pkg::bru_jal) || (iss.fun == exe_pkg::bru_jalr);

	always_comb begin
		taken = 1'b0;
		case (iss.fun)
			exe_pkg::bru_beq: taken = is_eq;
			exe_pkg::bru_bne: taken = ~is_eq;
			exe_pkg::bru_blt: taken = is_lt;
			exe_pkg::bru_bge: taken = ~is_lt;
			exe_pkg::bru_bltu: taken = is_ltu;
			exe_pkg::bru_bgeu: taken = ~is_ltu;
			exe_pkg::bru_jal: taken = 1'b1;
			exe_pkg::bru_jalr: taken = 1'b1;
		endcase
	end

	// jalr clears bit 0 of its computed target.
	assign target = (iss.fun == exe_pkg::bru_jalr) ? ((src1 + iss.imm) & ~rv64_pkg::xlen'(1))
		: (iss.pc + iss.imm);
	assign link = iss.pc + rv64_pkg::xlen'(rv64_pkg::inst_bytes);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_q <= 1'b0;
			redir_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= iss.valid & ~flush & is_jump;
			redir_valid_q <= iss.valid & ~flush & taken;
		end
	end

	always_ff @(posedge CLK) begin
		rd_q <= iss.rd;
		link_q <= link;
		target_q <= target;
	end

	assign wb = '{valid: wb_valid_q, rd: rd_q, res: link_q};
	assign redir = '{valid: redir_valid_q, pc: target_q};

	// A jump writes its link in the same cycle as its redirect.
	jump_redirects: assert property (@(posedge CLK) disable iff (!rst_n)
		wb.valid |-> redir.valid);

endmodule

// File: src/wb_merge.sv
/*
 * Merges the two unit results in program order, slot B being the younger op.
 * Purely combinational. Writes to register 0 are dropped.
 */
`timescale 1ns/1ps

module wb_merge (
	input logic CLK,
	input logic rst_n,
	input exe_pkg::wb_t alu_wb,
	input exe_pkg::wb_t bru_wb,
	input exe_pkg::redirect_t bru_redir,
	output logic we_a,
	output logic we_b,
	output logic [rv64_pkg::preg_w-1:0] wa_idx,
	output logic [rv64_pkg::preg_w-1:0] wb_idx,
	output logic [rv64_pkg::xlen-1:0] wa_data,
	output logic [rv64_pkg::xlen-1:0] wb_data,
	output exe_pkg::wb_t commit_a,
	output exe_pkg::wb_t commit_b,
	output exe_pkg::redirect_t redirect
);

	logic same_rd;

	// When both target the same register, the older ALU write is superseded.
	assign same_rd = alu_wb.valid && bru_wb.valid && (alu_wb.rd == bru_wb.rd);

	assign we_a = alu_wb.valid && (alu_wb.rd != '0) && !same_rd;
	assign we_b = bru_wb.valid && (bru_wb.rd != '0);

	assign wa_idx = alu_wb.rd;
	assign wb_idx = bru_wb.rd;
	assign wa_data = alu_wb.res;
	assign wb_data = bru_wb.res;

	assign commit_a = '{valid: we_a, rd: wa_idx, res: wa_data};
	assign commit_b = '{valid: we_b, rd: wb_idx, res: wb_data};

	assign redirect = bru_redir;

	write_ports_distinct: assert property (@(posedge CLK) disable iff (!rst_n)
		!(we_a && we_b && (wa_idx == wb_idx)));

endmodule

// File: src/exe_cluster.sv
/*
 * Integer execute cluster: register file, ALU, branch unit and writeback merger.
 * No bypass. A pair must not depend on the pair issued in the previous cycle.
 */
`timescale 1ns/1ps

module exe_cluster (
	input logic CLK,
	input logic rst_n,
	input logic flush,
	input exe_pkg::alu_issue_t alu_iss,
	input exe_pkg::bru_issue_t bru_iss,
	output exe_pkg::wb_t commit_a,
	output exe_pkg::wb_t commit_b,
	output exe_pkg::redirect_t redirect
);

	logic [rv64_pkg::preg_w-1:0] rd_idx [4];
	logic [rv64_pkg::xlen-1:0] rd_data [4];

	exe_pkg::wb_t alu_wb, bru_wb;
	exe_pkg::redirect_t bru_redir;

	logic we_a, we_b;
	logic [rv64_pkg::preg_w-1:0] wa_idx, wb_idx;
	logic [rv64_pkg::xlen-1:0] wa_data, wb_data;

	// Read ports 0 and 1 serve the ALU, ports 2 and 3 the branch unit.
	assign rd_idx[0] = alu_iss.rs1;
	assign rd_idx[1] = alu_iss.rs2;
	assign rd_idx[2] = bru_iss.rs1;
	assign rd_idx[3] = bru_iss.rs2;

	phys_regfile u_regfile (
		.CLK(CLK), .rst_n(rst_n),
		.ra_idx(rd_idx), .ra_data(rd_data),
		.we_a(we_a), .we_b(we_b), .wa_idx(wa_idx), .wb_idx(wb_idx),
		.wa_data(wa_data), .wb_data(wb_data)
	);

	alu_exe u_alu (
		.CLK(CLK), .rst_n(rst_n), .flush(flush),
		.iss(alu_iss), .src1(rd_data[0]), .src2(rd_data[1]), .wb(alu_wb)
	);

	bru_exe u_bru (
		.CLK(CLK), .rst_n(rst_n), .flush(flush),
		.iss(bru_iss), .src1(rd_data[2]), .src2(rd_data[3]),
		.wb(bru_wb), .redir(bru_redir)
	);

	wb_merge u_merge (
		.CLK(CLK), .rst_n(rst_n),
		.alu_wb(alu_wb), .bru_wb(bru_wb), .bru_redir(bru_redir),
		.we_a(we_a), .we_b(we_b), .wa_idx(wa_idx), .wb_idx(wb_idx),
		.wa_data(wa_data), .wb_data(wb_data),
		.commit_a(commit_a), .commit_b(commit_b), .redirect(redirect)
	);

endmodule

// File: test/tb_exe_cluster.sv
/*
 * Random and directed testbench for the execute cluster.
 * A pair that reads a register written by the previous pair gets a bubble first.
 */
`timescale 1ns/1ps

module tb_exe_cluster;

	typedef struct packed {
		logic taken;
		logic [rv64_pkg::xlen-1:0] target;
		logic [rv64_pkg::xlen-1:0] link;
	} bru_exp_t;

	typedef struct packed {
		logic [31:0] cyc;
		exe_pkg::wb_t ca;
		exe_pkg::wb_t cb;
		exe_pkg::redirect_t redir;
	} exp_t;

	logic CLK;
	logic rst_n;
	logic flush;
	exe_pkg::alu_issue_t alu_iss;
	exe_pkg::bru_issue_t bru_iss;
	exe_pkg::wb_t commit_a, commit_b;
	exe_pkg::redirect_t redirect;

	logic [rv64_pkg::xlen-1:0] model [rv64_pkg::preg_num];
	exp_t exp_q [$];
	logic [31:0] cyc = '0;
	logic last_a_v, last_b_v;
	logic [rv64_pkg::preg_w-1:0] last_a_rd, last_b_rd;

	exe_cluster uut (
		.CLK(CLK), .rst_n(rst_n), .flush(flush),
		.alu_iss(alu_iss), .bru_iss(bru_iss),
		.commit_a(commit_a), .commit_b(commit_b), .redirect(redirect)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#50 CLK = ~CLK;
		end
	end

	always @(posedge CLK) cyc <= cyc + 1;

	// Expected ALU result, taken from the instruction semantics.
	function automatic logic [63:0] alu_ref(input exe_pkg::alu_issue_t op,
		input logic [63:0] a, input logic [63:0] b);
		logic [63:0] op2;
		logic [5:0] sh;
		logic [63:0] r;
		op2 = op.is_imm ? op.imm : b;
		sh = op.is_shamt ? op.imm[5:0] : b[5:0];
		if (op.is32w)
			sh[5] = 1'b0;
		case (op.fun)
			exe_pkg::alu_imm: r = op.pc + op.imm;
			exe_pkg::alu_add: r = a + op2;
			exe_pkg::alu_sub: r = a - b;
			exe_pkg::alu_slt: begin
				if (op.is_usi)
					r = {63'b0, a < op2};
				else
					r = {63'b0, $signed(a) < $signed(op2)};
			end
			exe_pkg::alu_xor: r = a ^ op2;
			exe_pkg::alu_or: r = a | op2;
			exe_pkg::alu_and: r = a & op2;
			exe_pkg::alu_sll: r = a << sh;
			exe_pkg::alu_srl: r = op.is32w ? ({32'b0, a[31:0]} >> sh) : (a >> sh);
			exe_pkg::alu_sra: begin
				if (op.is32w)
					r = $signed({{32{a[31]}}, a[31:0]}) >>> sh;
				else
					r = $signed(a) >>> sh;
			end
			default: r = 'x;
		endcase
		if (op.is32w)
			r = {{32{r[31]}}, r[31:0]};
		return r;
	endfunction

	function automatic bru_exp_t bru_ref(input exe_pkg::bru_issue_t op,
		input logic [63:0] a, input logic [63:0] b);
		bru_exp_t e;
		case (op.fun)
			exe_pkg::bru_beq: e.taken = (a == b);
			exe_pkg::bru_bne: e.taken = (a != b);
			exe_pkg::bru_blt: e.taken = ($signed(a) < $signed(b));
			exe_pkg::bru_bge: e.taken = ($signed(a) >= $signed(b));
			exe_pkg::bru_bltu: e.taken = (a < b);
			exe_pkg::bru_bgeu: e.taken = (a >= b);
			default: e.taken = 1'b1;
		endcase
		if (op.fun == exe_pkg::bru_jalr)
			e.target = (a + op.imm) & ~64'h1;
		else
			e.target = op.pc + op.imm;
		e.link = op.pc + 64'd4;
		return e;
	endfunction

	function automatic logic [63:0] rand_word();
		return {$urandom, $urandom};
	endfunction

	function automatic logic [63:0] rand_imm12();
		logic [31:0] x;
		x = $urandom;
		return {{52{x[11]}}, x[11:0]};
	endfunction

	// True when idx was written by the pair issued in the previous cycle.
	function automatic logic reads_pending(input logic [rv64_pkg::preg_w-1:0] idx);
		return (last_a_v && last_a_rd == idx) || (last_b_v && last_b_rd == idx);
	endfunction

	task automatic check_value(input string name, input logic [63:0] expv,
		input logic [63:0] act);
		if (expv !== act) begin
			$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expv, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic insert_bubble();
		exp_t e;
		@(posedge CLK);
		#5;
		alu_iss = '0;
		bru_iss = '0;
		flush = 1'b0;
		e = '0;
		e.cyc = cyc;
		exp_q.push_back(e);
		last_a_v = 1'b0;
		last_b_v = 1'b0;
	endtask

	task automatic issue_pair(input exe_pkg::alu_issue_t a, input exe_pkg::bru_issue_t b,
		input logic fl);
		exp_t e;
		logic [63:0] alu_res;
		bru_exp_t br;
		logic a_wr, b_wr;
		if ((a.valid && (reads_pending(a.rs1) || reads_pending(a.rs2)))
			|| (b.valid && (reads_pending(b.rs1) || reads_pending(b.rs2))))
			insert_bubble();
		@(posedge CLK);
		#5;
		alu_iss = a;
		bru_iss = b;
		flush = fl;
		alu_res = alu_ref(a, model[a.rs1], model[a.rs2]);
		br = bru_ref(b, model[b.rs1], model[b.rs2]);
		b_wr = b.valid && !fl && (b.fun == exe_pkg::bru_jal || b.fun == exe_pkg::bru_jalr);
		// The younger branch link wins a shared destination.
		a_wr = a.valid && !fl && !(b_wr && a.rd == b.rd);
		e.cyc = cyc;
		e.ca = '{valid: a_wr && a.rd != '0, rd: a.rd, res: alu_res};
		e.cb = '{valid: b_wr && b.rd != '0, rd: b.rd, res: br.link};
		e.redir = '{valid: b.valid && !fl && br.taken, pc: br.target};
		exp_q.push_back(e);
		if (e.ca.valid)
			model[a.rd] = alu_res;
		if (e.cb.valid)
			model[b.rd] = br.link;
		last_a_v = e.ca.valid;
		last_a_rd = a.rd;
		last_b_v = e.cb.valid;
		last_b_rd = b.rd;
	endtask

	always @(negedge CLK) begin : compare_commits
		exp_t e;
		if (exp_q.size() != 0 && exp_q[0].cyc < cyc) begin
			e = exp_q.pop_front();
			check_value("commit_a.valid", 64'(e.ca.valid), 64'(commit_a.valid));
			if (e.ca.valid) begin
				check_value("commit_a.rd", 64'(e.ca.rd), 64'(commit_a.rd));
				check_value("commit_a.res", e.ca.res, commit_a.res);
			end
			check_value("commit_b.valid", 64'(e.cb.valid), 64'(commit_b.valid));
			if (e.cb.valid) begin
				check_value("commit_b.rd", 64'(e.cb.rd), 64'(commit_b.rd));
				check_value("commit_b.res", e.cb.res, commit_b.res);
			end
			check_value("redirect.valid", 64'(e.redir.valid), 64'(redirect.valid));
			if (e.redir.valid)
				check_value("redirect.pc", e.redir.pc, redirect.pc);
		end
	end

	initial begin
		exe_pkg::alu_issue_t a;
		exe_pkg::bru_issue_t b;
		logic [63:0] shamt_tab [5];
		logic [63:0] special [4];
		int waited;
		void'($urandom(10));
		alu_iss = '0;
		bru_iss = '0;
		flush = 1'b0;
		rst_n = 1'b0;
		last_a_v = 1'b0;
		last_b_v = 1'b0;
		last_a_rd = '0;
		last_b_rd = '0;
		for (int r = 0; r < rv64_pkg::preg_num; r++)
			model[r] = '0;
		shamt_tab = '{64'd0, 64'd31, 64'd32, 64'd63, 64'd17};
		special = '{64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF,
			64'h0000_0000_8000_0000, 64'h7FFF_FFFF_FFFF_FFFF};
		repeat (10) @(posedge CLK);
		#5;
		rst_n = 1'b1;

		// Idle after reset, then every register must read zero through an add.
		repeat (3) insert_bubble();
		for (int r = 1; r < rv64_pkg::preg_num; r++) begin
			a = '0;
			a.valid = 1'b1;
			a.fun = exe_pkg::alu_add;
			a.rs1 = 6'(r);
			a.rs2 = 6'(r);
			a.rd = 6'(r);
			issue_pair(a, '0, 1'b0);
		end

		// Load every register with pc-relative immediate adds at pc zero.
		for (int r = 1; r < rv64_pkg::preg_num; r++) begin
			a = '0;
			a.valid = 1'b1;
			a.fun = exe_pkg::alu_imm;
			a.rd = 6'(r);
			a.imm = (r < 5) ? special[r-1] : rand_word();
			issue_pair(a, '0, 1'b0);
		end

		// Mixed traffic. The index walks through functions, W form and operand kind.
		for (int i = 0; i < 400; i++) begin
			a = '0;
			a.valid = 1'b1;
			a.fun = exe_pkg::alu_fun_e'(4'(i % 10));
			a.is32w = 1'((i / 10) % 2);
			a.is_imm = 1'((i / 20) % 2) && (a.fun != exe_pkg::alu_sub);
			a.is_usi = 1'($urandom);
			a.is_shamt = a.is_imm && (a.fun == exe_pkg::alu_sll
				|| a.fun == exe_pkg::alu_srl || a.fun == exe_pkg::alu_sra);
			a.rs1 = 6'($urandom);
			a.rs2 = 6'($urandom);
			a.rd = 6'($urandom);
			a.pc = rand_word() & ~64'h3;
			a.imm = a.is_shamt ? shamt_tab[(i / 40) % 5] : rand_imm12();
			if (a.fun == exe_pkg::alu_imm)
				a.imm = rand_word();
			b = '0;
			b.valid = ($urandom % 8) != 0;
			b.fun = exe_pkg::bru_fun_e'(3'($urandom));
			b.rs1 = 6'($urandom);
			b.rs2 = ($urandom % 4 == 0) ? b.rs1 : 6'($urandom);
			b.rd = ($urandom % 8 == 0) ? a.rd : 6'($urandom);
			b.pc = rand_word() & ~64'h3;
			b.imm = rand_imm12() & ~64'h1;
			issue_pair(a, b, 1'b0);
		end

		// Same destination in one pair, then writes to register 0.
		a = '{valid: 1'b1, fun: exe_pkg::alu_add, rs1: 6'd3, rs2: 6'd4, rd: 6'd7, default: '0};
		b = '{valid: 1'b1, fun: exe_pkg::bru_jal, rd: 6'd7, pc: 64'h1000, imm: 64'h40, default: '0};
		issue_pair(a, b, 1'b0);
		a.rd = 6'd0;
		b.rd = 6'd0;
		issue_pair(a, b, 1'b0);
		a = '{valid: 1'b1, fun: exe_pkg::alu_add, rs1: 6'd0, rs2: 6'd0, rd: 6'd9, default: '0};
		b = '{valid: 1'b1, fun: exe_pkg::bru_jalr, rs1: 6'd0, rd: 6'd10, pc: 64'h2000,
			imm: 64'h123, default: '0};
		issue_pair(a, b, 1'b0);
		a = '{valid: 1'b1, fun: exe_pkg::alu_add, rs1: 6'd7, rs2: 6'd0, rd: 6'd11, default: '0};
		issue_pair(a, '0, 1'b0);

		// The middle pair is flushed. Its neighbors commit normally.
		a = '{valid: 1'b1, fun: exe_pkg::alu_xor, rs1: 6'd5, rs2: 6'd6, rd: 6'd12, default: '0};
		b = '{valid: 1'b1, fun: exe_pkg::bru_jal, rd: 6'd13, pc: 64'h3000, imm: 64'h8, default: '0};
		issue_pair(a, b, 1'b0);
		a.rd = 6'd14;
		b.rd = 6'd14;
		issue_pair(a, b, 1'b1);
		a = '{valid: 1'b1, fun: exe_pkg::alu_or, rs1: 6'd12, rs2: 6'd14, rd: 6'd15, default: '0};
		b = '{valid: 1'b1, fun: exe_pkg::bru_beq, rs1: 6'd13, rs2: 6'd13, pc: 64'h4000,
			imm: 64'h10, default: '0};
		issue_pair(a, b, 1'b0);
		repeat (2) insert_bubble();

		waited = 0;
		while (exp_q.size() != 0 && waited < 20) begin
			@(posedge CLK);
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout: %0d expected results never came out of the cluster", exp_q.size());
			$display("TEST FAILED");
			$fatal(1);
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// File: verilog.f
src/rv64_pkg.sv
src/exe_pkg.sv
src/phys_regfile.sv
src/alu_exe.sv
src/bru_exe.sv
src/wb_merge.sv
src/exe_cluster.sv
test/tb_exe_cluster.sv

// File: build.sh
#!/bin/sh
# Builds the execute cluster testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_exe_cluster -f verilog.f \
	-Mdir obj_dir -o sim_exe_cluster
if [ $? -ne 0 ]; then
	echo "build: Verilator compile failed"
	exit 1
fi

./obj_dir/sim_exe_cluster > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "build: simulation exited with status $run_status"
	exit 1
fi

if grep -q "^TEST OK$" sim.log; then
	echo "build: simulation passed"
	exit 0
else
	echo "build: pass message not found in sim.log"
	exit 1
fi
